//--- flist.f
+incdir+.
lpddr2_pkg.sv
mem_cmd_if.sv
lpddr2_req_sync.sv
lpddr2_ctrl.sv
lpddr2_avl_port.sv
lpddr2_memory.sv
lpddr2_checker.sv
tb_lpddr2_memory.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the lpddr2 bridge testbench with verilator.

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lpddr2_memory -f flist.f -o sim_lpddr2
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lpddr2 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_lpddr2_memory.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

module tb_lpddr2_memory;

    localparam int NUM_OPS        = 200;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 64 + 200;

    logic                      iCLK = 1'b0;
    logic                      iRST_n, i_cpu_clk, read_req_raw, write_req_raw, local_init_done;
    logic                      avl_waitrequest_n, avl_readdatavalid;
    logic                      avl_read, avl_write, avl_burstbegin;
    logic [`LPDDR2_ADDR_W-1:0] addr, avl_address;
    logic [`LPDDR2_DATA_W-1:0] in_data, out_data, avl_readdata, avl_writedata;
    lpddr2_pkg::bridge_state_t state;
    int                        error_count, cmd_count;

    integer                    seed = 20922;
    int                        phase;         // position in the cpu clock period.
    int                        cycle_cnt = 0;
    int                        rd_cnt;
    logic [5:0]                rd_addr;
    logic                      next_wrn;
    logic [`LPDDR2_DATA_W-1:0] mem [64];      // slave memory, low words only.

    lpddr2_memory lpddr2_memory_inst (.*);
    lpddr2_checker checker_inst (.*);

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    task automatic advance_cycle();
        @(posedge iCLK);
        #2;
        phase     = (phase + 1) % 8;
        i_cpu_clk = (phase < 4); // iCLK divided by 8.
    endtask

    task automatic wait_idle();
        while (state != lpddr2_pkg::IDLE) advance_cycle();
    endtask

    always #20 iCLK = ~iCLK;

    always @(posedge iCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // avalon slave, decides at negedge and drives after the edge.
    always begin
        @(negedge iCLK);
        if (iRST_n && avl_waitrequest_n && avl_write) mem[avl_address[5:0]] = avl_writedata;
        if (iRST_n && avl_waitrequest_n && avl_read) begin
            rd_addr = avl_address[5:0];
            rd_cnt  = 1 + rand_below(4);
        end
        next_wrn = rand_below(4) != 0;
        @(posedge iCLK);
        #2;
        avl_waitrequest_n = next_wrn;
        avl_readdatavalid = 1'b0;
        if (rd_cnt > 0) begin
            rd_cnt--;
            avl_readdatavalid = (rd_cnt == 0);
            avl_readdata      = mem[rd_addr];
        end
    end

    initial begin
        int   start;
        logic is_read;
        {iRST_n, i_cpu_clk, read_req_raw, write_req_raw, local_init_done} = '0;
        {avl_waitrequest_n, avl_readdatavalid} = '0;
        addr         = '0;
        in_data      = '0;
        avl_readdata = '0;
        phase        = 0;
        rd_cnt       = 0;
        for (int k = 0; k < 64; k++) begin
            mem[k] = '0;
        end
        repeat (10) advance_cycle();
        iRST_n = 1'b1;
        repeat (16 + rand_below(21)) begin
            advance_cycle(); // requests toggle during calibration.
            read_req_raw  = rand_below(2) != 0;
            write_req_raw = rand_below(2) != 0;
        end
        advance_cycle();
        {read_req_raw, write_req_raw} = '0;
        repeat (3) advance_cycle();
        local_init_done = 1'b1;
        for (int op = 0; op < NUM_OPS; op++) begin
            is_read = rand_below(2) != 0;
            wait_idle();
            do begin
                advance_cycle();
            end while (phase != 1);
            addr    = `LPDDR2_ADDR_W'(rand_below(64));
            in_data = $random(seed);
            start   = cycle_cnt;
            if (is_read) read_req_raw = 1'b1;
            else write_req_raw = 1'b1;
            repeat (2) advance_cycle(); // pulse, then the state leaves IDLE.
            wait_idle();
            // a fast read leaves room for a second edge in the same period.
            if (is_read && cycle_cnt - start <= 5) begin
                read_req_raw = 1'b0;
                advance_cycle();
                read_req_raw = 1'b1;
            end
            repeat (rand_below(8)) advance_cycle();
            {read_req_raw, write_req_raw} = '0;
        end
        repeat (10) advance_cycle();
        if (cmd_count != NUM_OPS)
            $display("[FAIL] %0d ns: expected %0d Avalon commands but saw %0d",
                     $time, NUM_OPS, cmd_count);
        $display("errors: %0d, Avalon commands: %0d of %0d", error_count, cmd_count, NUM_OPS);
        if (error_count == 0 && cmd_count == NUM_OPS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- lpddr2_checker.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

module lpddr2_checker (
    input  logic                       iCLK, iRST_n, i_cpu_clk, local_init_done,
    input  logic                       read_req_raw, write_req_raw,
    input  logic [`LPDDR2_ADDR_W-1:0]  addr, avl_address,
    input  logic [`LPDDR2_DATA_W-1:0]  in_data, out_data, avl_writedata,
    input  logic                       avl_waitrequest_n, avl_readdatavalid,
    input  logic                       avl_read, avl_write, avl_burstbegin,
    input  lpddr2_pkg::bridge_state_t  state,
    output int                         error_count, cmd_count
);

    logic                      cpu_prev, rd_prev, wr_prev, allow, rd_pulse, wr_pulse, rd_edge;
    logic                      ready, busy, rd_wait, chk_rd, st_ok;
    logic                      exp_valid, exp_write;
    int                        ret_cnt;
    logic [`LPDDR2_ADDR_W-1:0] exp_addr;
    logic [`LPDDR2_DATA_W-1:0] exp_data, exp_rdata;
    logic [`LPDDR2_DATA_W-1:0] ref_mem [64];

    task automatic flag_error(input string msg);
        error_count++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    // each negedge predicts what the following rising edge does.
    always @(negedge iCLK) begin
        if (!iRST_n) begin
            {cpu_prev, rd_prev, wr_prev, allow, rd_pulse, wr_pulse} = '0;
            {ready, busy, rd_wait, chk_rd, exp_valid} = '0;
            ret_cnt     = 0;
            error_count = 0;
            cmd_count   = 0;
            for (int k = 0; k < 64; k++) begin
                ref_mem[k] = '0;
            end
        end else begin
            if (ret_cnt > 0) begin
                ret_cnt--; // done, then back to IDLE.
                if (ret_cnt == 1 && chk_rd && out_data !== exp_rdata)
                    flag_error($sformatf("out_data %h, expected %h", out_data, exp_rdata));
                if (ret_cnt == 0) busy = 1'b0;
            end
            if (!ready) st_ok = (state == lpddr2_pkg::INIT);
            else if (!busy) st_ok = (state == lpddr2_pkg::IDLE);
            else st_ok = (state != lpddr2_pkg::INIT) && (state != lpddr2_pkg::IDLE);
            if (!st_ok)
                flag_error($sformatf("state %0d, expected %s", state,
                                     !ready ? "INIT" : (busy ? "a busy state" : "IDLE")));
            if (!ready && (avl_read || avl_write))
                flag_error("Avalon strobe raised during calibration");
            if (avl_burstbegin !== (avl_read | avl_write))
                flag_error("avl_burstbegin differs from avl_read | avl_write");
            if ((avl_read || avl_write) && avl_waitrequest_n) begin
                cmd_count++;
                if (!exp_valid)
                    flag_error("Avalon command without an accepted request");
                else if (avl_write !== exp_write || avl_address !== exp_addr)
                    flag_error($sformatf("command write=%0b addr %h, expected write=%0b addr %h",
                                         avl_write, avl_address, exp_write, exp_addr));
                else if (exp_write && avl_writedata !== exp_data)
                    flag_error($sformatf("writedata %h, expected %h", avl_writedata, exp_data));
                exp_valid = 1'b0;
                rd_wait   = avl_read;
                chk_rd    = 1'b0;
                if (avl_write) ret_cnt = 2;
            end
            if (rd_wait && avl_readdatavalid) begin
                rd_wait = 1'b0;
                chk_rd  = 1'b1;
                ret_cnt = 2;
            end
            if (!ready) begin
                ready = local_init_done; // pulses in INIT are dropped.
            end else if (!busy && (rd_pulse || wr_pulse)) begin
                busy      = 1'b1;
                exp_valid = 1'b1;
                exp_write = !rd_pulse;
                exp_addr  = addr;
                exp_data  = in_data;
                if (rd_pulse) exp_rdata = ref_mem[addr[5:0]];
                else ref_mem[addr[5:0]] = in_data;
            end
            // one accepted edge per cpu clock period, read first.
            rd_edge  = read_req_raw && !rd_prev;
            rd_pulse = rd_edge && allow;
            wr_pulse = write_req_raw && !wr_prev && !rd_edge && allow;
            if (i_cpu_clk && !cpu_prev) allow = 1'b1;
            else if (rd_pulse || wr_pulse) allow = 1'b0;
            cpu_prev = i_cpu_clk;
            rd_prev  = read_req_raw;
            wr_prev  = write_req_raw;
        end
    end

endmodule

//--- lpddr2_memory.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

module lpddr2_memory (
    input  logic                       iCLK,
    input  logic                       iRST_n,
    input  logic                       i_cpu_clk,
    input  logic                       read_req_raw,
    input  logic                       write_req_raw,
    input  logic [`LPDDR2_ADDR_W-1:0]  addr,
    input  logic [`LPDDR2_DATA_W-1:0]  in_data,
    output logic [`LPDDR2_DATA_W-1:0]  out_data,
    input  logic                       local_init_done,
    input  logic                       avl_waitrequest_n,
    output logic [`LPDDR2_ADDR_W-1:0]  avl_address,
    input  logic                       avl_readdatavalid,
    input  logic [`LPDDR2_DATA_W-1:0]  avl_readdata,
    output logic [`LPDDR2_DATA_W-1:0]  avl_writedata,
    output logic                       avl_read,
    output logic                       avl_write,
    output logic                       avl_burstbegin,
    output lpddr2_pkg::bridge_state_t  state
);

    logic read_pulse;
    logic write_pulse;

    mem_cmd_if cmd_bus ();

    lpddr2_req_sync req_sync_inst (
        .iCLK          (iCLK),
        .iRST_n        (iRST_n),
        .i_cpu_clk     (i_cpu_clk),
        .read_req_raw  (read_req_raw),
        .write_req_raw (write_req_raw),
        .read_pulse    (read_pulse),
        .write_pulse   (write_pulse)
    );

    lpddr2_ctrl ctrl_inst (
        .iCLK            (iCLK),
        .iRST_n          (iRST_n),
        .local_init_done (local_init_done),
        .read_pulse      (read_pulse),
        .write_pulse     (write_pulse),
        .addr            (addr),
        .in_data         (in_data),
        .state           (state),
        .cmd_bus         (cmd_bus.ctrl)
    );

    lpddr2_avl_port avl_port_inst (
        .iCLK              (iCLK),
        .iRST_n            (iRST_n),
        .avl_waitrequest_n (avl_waitrequest_n),
        .avl_readdatavalid (avl_readdatavalid),
        .avl_readdata      (avl_readdata),
        .avl_address       (avl_address),
        .avl_writedata     (avl_writedata),
        .avl_read          (avl_read),
        .avl_write         (avl_write),
        .avl_burstbegin    (avl_burstbegin),
        .out_data          (out_data),
        .cmd_bus           (cmd_bus.port)
    );

endmodule

//--- lpddr2_avl_port.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

module lpddr2_avl_port (
    input  logic                       iCLK,
    input  logic                       iRST_n,
    input  logic                       avl_waitrequest_n,
    input  logic                       avl_readdatavalid,
    input  logic [`LPDDR2_DATA_W-1:0]  avl_readdata,
    output logic [`LPDDR2_ADDR_W-1:0]  avl_address,
    output logic [`LPDDR2_DATA_W-1:0]  avl_writedata,
    output logic                       avl_read,
    output logic                       avl_write,
    output logic                       avl_burstbegin,
    output logic [`LPDDR2_DATA_W-1:0]  out_data,
    mem_cmd_if.port                    cmd_bus
);

    logic rd_pending; // read accepted, data not yet back.

    assign avl_burstbegin = avl_read | avl_write;

    always_ff @(posedge iCLK) begin
        if (cmd_bus.cmd != lpddr2_pkg::CMD_NONE) begin
            avl_address <= cmd_bus.addr;
        end
        if (cmd_bus.cmd == lpddr2_pkg::CMD_WRITE) begin
            avl_writedata <= cmd_bus.wdata;
        end
    end

    always_ff @(posedge iCLK) begin
        if (!iRST_n) begin
            avl_read            <= 1'b0;
            avl_write           <= 1'b0;
            rd_pending          <= 1'b0;
            cmd_bus.done        <= 1'b0;
            cmd_bus.rdata_valid <= 1'b0;
            out_data            <= '0;
        end else begin
            cmd_bus.done        <= 1'b0;
            cmd_bus.rdata_valid <= 1'b0;
            if (cmd_bus.cmd == lpddr2_pkg::CMD_READ) begin
                avl_read <= 1'b1;
            end else if (cmd_bus.cmd == lpddr2_pkg::CMD_WRITE) begin
                avl_write <= 1'b1;
            end
            if (avl_write && avl_waitrequest_n) begin
                avl_write    <= 1'b0;
                cmd_bus.done <= 1'b1; // write done on acceptance.
            end
            if (avl_read && avl_waitrequest_n) begin
                avl_read   <= 1'b0;
                rd_pending <= 1'b1;
            end
            if (rd_pending && avl_readdatavalid) begin
                rd_pending          <= 1'b0;
                out_data            <= avl_readdata;
                cmd_bus.done        <= 1'b1;
                cmd_bus.rdata_valid <= 1'b1;
            end
        end
    end

    // held under back-pressure.
    a_hold_stable: assert property (@(posedge iCLK) disable iff (!iRST_n)
        (avl_burstbegin && !avl_waitrequest_n) |=>
            $stable(avl_address) && $stable(avl_read) && $stable(avl_write) &&
            (!avl_write || $stable(avl_writedata)));

    a_rd_wr_excl: assert property (@(posedge iCLK) disable iff (!iRST_n)
        !(avl_read && avl_write));

endmodule

//--- lpddr2_ctrl.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

module lpddr2_ctrl (
    input  logic                       iCLK,
    input  logic                       iRST_n,
    input  logic                       local_init_done,
    input  logic                       read_pulse,
    input  logic                       write_pulse,
    input  logic [`LPDDR2_ADDR_W-1:0]  addr,
    input  logic [`LPDDR2_DATA_W-1:0]  in_data,
    output lpddr2_pkg::bridge_state_t  state,
    mem_cmd_if.ctrl                    cmd_bus
);

    localparam int CNT_W = $clog2(`LPDDR2_SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] settle_cnt;
    logic             settle_last;

    assign settle_last = (state == lpddr2_pkg::WRITE) &&
                         (settle_cnt == CNT_W'(`LPDDR2_SETTLE_CYCLES - 1));

    // address and data are taken straight from the cpu side when the command fires.
    assign cmd_bus.addr  = addr;
    assign cmd_bus.wdata = in_data;

    always_comb begin
        cmd_bus.cmd = lpddr2_pkg::CMD_NONE;
        if (state == lpddr2_pkg::IDLE && read_pulse) begin
            cmd_bus.cmd = lpddr2_pkg::CMD_READ;
        end else if (settle_last) begin
            cmd_bus.cmd = lpddr2_pkg::CMD_WRITE;
        end
    end

    always_ff @(posedge iCLK) begin
        if (!iRST_n) begin
            state      <= lpddr2_pkg::INIT;
            settle_cnt <= '0;
        end else begin
            case (state)
                lpddr2_pkg::INIT: begin
                    if (local_init_done) begin
                        state <= lpddr2_pkg::IDLE; // calibration finished.
                    end
                end
                lpddr2_pkg::IDLE: begin
                    settle_cnt <= '0;
                    if (read_pulse) begin
                        state <= lpddr2_pkg::READ;
                    end else if (write_pulse) begin
                        state <= lpddr2_pkg::WRITE;
                    end
                end
                lpddr2_pkg::WRITE: begin
                    if (settle_last) begin
                        state <= lpddr2_pkg::WAIT_WRITE;
                    end else begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end
                end
                lpddr2_pkg::WAIT_WRITE: begin
                    if (cmd_bus.done) begin
                        state <= lpddr2_pkg::IDLE;
                    end
                end
                // avl_read goes up here, acceptance and data follow in wait_read.
                lpddr2_pkg::READ: state <= lpddr2_pkg::WAIT_READ;
                lpddr2_pkg::WAIT_READ: begin
                    if (cmd_bus.done) begin
                        state <= lpddr2_pkg::IDLE;
                    end
                end
                default: state <= lpddr2_pkg::INIT;
            endcase
        end
    end

    // a write fires a full settle count after idle.
    a_write_settle: assert property (@(posedge iCLK) disable iff (!iRST_n)
        (cmd_bus.cmd == lpddr2_pkg::CMD_WRITE) |->
            $past(state, `LPDDR2_SETTLE_CYCLES) == lpddr2_pkg::IDLE);

    // done must match the kind of wait we are in.
    a_done_in_wait: assert property (@(posedge iCLK) disable iff (!iRST_n)
        cmd_bus.done |-> state == (cmd_bus.rdata_valid ? lpddr2_pkg::WAIT_READ
                                                       : lpddr2_pkg::WAIT_WRITE));

endmodule

//--- lpddr2_req_sync.sv
`timescale 1ns/1ps

module lpddr2_req_sync (
    input  logic iCLK,
    input  logic iRST_n,
    input  logic i_cpu_clk,
    input  logic read_req_raw,
    input  logic write_req_raw,
    output logic read_pulse,
    output logic write_pulse
);

    logic cpu_clk_prev;
    logic read_prev;
    logic write_prev;
    logic allow;
    logic cpu_rise;
    logic read_edge;
    logic write_edge;
    logic read_take;
    logic write_take;

    assign cpu_rise   = i_cpu_clk & ~cpu_clk_prev;
    assign read_edge  = read_req_raw & ~read_prev;
    assign write_edge = write_req_raw & ~write_prev;

    // read wins a tie.
    assign read_take  = read_edge & allow;
    assign write_take = write_edge & ~read_edge & allow;

    always_ff @(posedge iCLK) begin
        if (!iRST_n) begin
            cpu_clk_prev <= 1'b0;
            read_prev    <= 1'b0;
            write_prev   <= 1'b0;
            allow        <= 1'b0;
            read_pulse   <= 1'b0;
            write_pulse  <= 1'b0;
        end else begin
            cpu_clk_prev <= i_cpu_clk;
            read_prev    <= read_req_raw;
            write_prev   <= write_req_raw;
            read_pulse   <= read_take;
            write_pulse  <= write_take;
            if (cpu_rise) begin
                allow <= 1'b1; // new cpu period.
            end else if (read_take || write_take) begin
                allow <= 1'b0;
            end
        end
    end

    // a second pulse needs a new cpu period.
    a_one_per_period: assert property (@(posedge iCLK) disable iff (!iRST_n)
        (read_pulse || write_pulse) && !$past(cpu_rise) |=> !(read_pulse || write_pulse));

endmodule

//--- mem_cmd_if.sv
`timescale 1ns/1ps
`include "lpddr2_settings.svh"

interface mem_cmd_if;

    lpddr2_pkg::mem_cmd_t        cmd;         // one-cycle pulse.
    logic [`LPDDR2_ADDR_W-1:0]   addr;
    logic [`LPDDR2_DATA_W-1:0]   wdata;
    logic                        done;        // command finished.
    logic                        rdata_valid; // with done, reads only.

    modport ctrl (
        output cmd,
        output addr,
        output wdata,
        input  done,
        input  rdata_valid
    );

    modport port (
        input  cmd,
        input  addr,
        input  wdata,
        output done,
        output rdata_valid
    );

endinterface

//--- lpddr2_pkg.sv
`include "lpddr2_settings.svh"

package lpddr2_pkg;

    // exported on the state port, codes are fixed.
    typedef enum logic [`LPDDR2_STATE_W-1:0] {
        INIT       = `LPDDR2_STATE_W'd0,
        IDLE       = `LPDDR2_STATE_W'd1,
        WRITE      = `LPDDR2_STATE_W'd2,
        WAIT_WRITE = `LPDDR2_STATE_W'd3,
        READ       = `LPDDR2_STATE_W'd4,
        WAIT_READ  = `LPDDR2_STATE_W'd5
    } bridge_state_t;

    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } mem_cmd_t;

endpackage

//--- lpddr2_settings.svh
`ifndef LPDDR2_SETTINGS_SVH
`define LPDDR2_SETTINGS_SVH

// avalon word address.
`define LPDDR2_ADDR_W 27

`define LPDDR2_DATA_W 32

// iclk cycles a write waits for cpu-side values to settle.
`define LPDDR2_SETTLE_CYCLES 8

`define LPDDR2_STATE_W 4

`endif
